// File: src/rv_pkg.sv
// --------------------------------------
// Shared RV32I definitions for the core
// Only the opcodes of the supported subset are listed
// --------------------------------------
`default_nettype none

package rv_pkg;

  // Data and address width, one word
  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  // --------------------------------------
  // Major opcodes
  // --------------------------------------
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  // ALU operations, pass_b feeds operand B straight through
  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_fn_t;

  // Register write-back source
  typedef enum logic [1:0] {
    wb_alu, wb_mem, wb_pc_plus4, wb_imm
  } wb_sel_t;

  // Next PC source
  typedef enum logic [1:0] {
    pc_plus4, pc_plus_imm, pc_alu
  } pc_sel_t;

endpackage

`default_nettype wire

// File: src/alu.sv
// --------------------------------------
// 32-bit ALU, purely combinational
// Shift amounts use operand_b[4:0] only
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module alu import rv_pkg::*; (
  input  alu_fn_t           alu_function,
  input  logic [xlen-1:0]   operand_a,
  input  logic [xlen-1:0]   operand_b,
  output logic [xlen-1:0]   result,
  output logic              result_equal_zero
);

  logic [4:0] shamt;

  assign shamt = operand_b[4:0];

  always_comb begin
    case (alu_function)
      alu_add:    result = operand_a + operand_b;
      alu_sub:    result = operand_a - operand_b;
      alu_sll:    result = operand_a << shamt;
      alu_slt:    result = {31'b0, $signed(operand_a) < $signed(operand_b)};
      alu_sltu:   result = {31'b0, operand_a < operand_b};
      alu_xor:    result = operand_a ^ operand_b;
      alu_srl:    result = operand_a >> shamt;
      alu_sra:    result = $unsigned($signed(operand_a) >>> shamt);
      alu_or:     result = operand_a | operand_b;
      alu_and:    result = operand_a & operand_b;
      alu_pass_b: result = operand_b;
      default:    result = '0;
    endcase
  end

  // Branch decisions rely on this flag
  assign result_equal_zero = (result == '0);

endmodule

`default_nettype wire

// File: src/regfile.sv
// --------------------------------------
// 32 x 32-bit registers, no reset
// x0 reads zero, writes to it are dropped
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module regfile import rv_pkg::*; (
  input  logic                  clock,
  input  logic                  write_enable,
  input  logic [reg_addr_w-1:0] rd_address,
  input  logic [reg_addr_w-1:0] rs1_address,
  input  logic [reg_addr_w-1:0] rs2_address,
  input  logic [xlen-1:0]       rd_data,
  output logic [xlen-1:0]       rs1_data,
  output logic [xlen-1:0]       rs2_data
);

  logic [xlen-1:0] regs [2**reg_addr_w];

  always_ff @(posedge clock) begin
    if (write_enable && rd_address != '0) begin
      regs[rd_address] <= rd_data;
    end
  end

  // Combinational reads
  assign rs1_data = (rs1_address == '0) ? '0 : regs[rs1_address];
  assign rs2_data = (rs2_address == '0) ? '0 : regs[rs2_address];

endmodule

`default_nettype wire

// File: src/immediate_generator.sv
// --------------------------------------
// Sign-extended immediate, I/S/B/U/J formats
// Opcodes outside the subset give zero
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module immediate_generator import rv_pkg::*; (
  input  logic [xlen-1:0] inst,
  output logic [xlen-1:0] immediate
);

  always_comb begin
    case (inst[6:0])
      // I format
      op_imm, op_load, op_jalr:
        immediate = {{20{inst[31]}}, inst[31:20]};
      op_store:
        immediate = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      op_branch:
        immediate = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      // Upper immediates
      op_lui, op_auipc:
        immediate = {inst[31:12], 12'b0};
      op_jal:
        immediate = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default:
        immediate = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/singlecycle_datapath.sv
// --------------------------------------
// Single-cycle data path, one instruction per clock
// reset_pc must be word aligned
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module singlecycle_datapath import rv_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic            clock,
  input  logic            arst_n,
  input  logic [xlen-1:0] inst,
  input  logic [xlen-1:0] data_mem_read_data,
  input  logic            regfile_write_enable,
  input  logic            alu_operand_a_select,
  input  logic            alu_operand_b_select,
  input  wb_sel_t         reg_writeback_select,
  input  pc_sel_t         next_pc_select,
  input  alu_fn_t         alu_function,
  output logic [xlen-1:0] data_mem_address,
  output logic [xlen-1:0] data_mem_write_data,
  output logic [xlen-1:0] pc,
  output logic [6:0]      inst_opcode,
  output logic [2:0]      inst_funct3,
  output logic [6:0]      inst_funct7,
  output logic            alu_result_equal_zero
);

  logic [reg_addr_w-1:0] inst_rd, inst_rs1, inst_rs2;
  logic [xlen-1:0] rs1_data, rs2_data, immediate;
  logic [xlen-1:0] operand_a, operand_b, alu_result;
  logic [xlen-1:0] pc_plus_4, pc_plus_immediate, next_pc, writeback_data;

  // --------------------------------------
  // Field decode
  // --------------------------------------
  assign inst_opcode = inst[6:0];
  assign inst_rd     = inst[11:7];
  assign inst_funct3 = inst[14:12];
  assign inst_rs1    = inst[19:15];
  assign inst_rs2    = inst[24:20];
  assign inst_funct7 = inst[31:25];

  immediate_generator igen (.inst(inst), .immediate(immediate));

  regfile regs (
    .clock(clock), .write_enable(regfile_write_enable),
    .rd_address(inst_rd), .rs1_address(inst_rs1), .rs2_address(inst_rs2),
    .rd_data(writeback_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  assign operand_a = alu_operand_a_select ? pc : rs1_data;
  assign operand_b = alu_operand_b_select ? immediate : rs2_data;

  alu alu_core (
    .alu_function(alu_function), .operand_a(operand_a), .operand_b(operand_b),
    .result(alu_result), .result_equal_zero(alu_result_equal_zero)
  );

  // --------------------------------------
  // PC update and write-back
  // --------------------------------------
  assign pc_plus_4         = pc + 32'd4;
  assign pc_plus_immediate = pc + immediate;

  always_comb begin
    case (next_pc_select)
      pc_plus_imm: next_pc = pc_plus_immediate;
      pc_alu:      next_pc = {alu_result[xlen-1:1], 1'b0};
      default:     next_pc = pc_plus_4;
    endcase
    case (reg_writeback_select)
      wb_mem:      writeback_data = data_mem_read_data;
      wb_pc_plus4: writeback_data = pc_plus_4;
      wb_imm:      writeback_data = immediate;
      default:     writeback_data = alu_result;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) pc <= reset_pc;
    else         pc <= next_pc;
  end

  assign data_mem_address    = alu_result;
  assign data_mem_write_data = rs2_data;

endmodule

`default_nettype wire

// File: src/control_unit.sv
// --------------------------------------
// Combinational decode of the RV32I subset
// Unknown opcodes decode as a no-op
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module control_unit import rv_pkg::*; (
  input  logic [6:0] inst_opcode,
  input  logic [2:0] inst_funct3,
  input  logic [6:0] inst_funct7,
  input  logic       alu_result_equal_zero,
  output logic       regfile_write_enable,
  output logic       alu_operand_a_select,
  output logic       alu_operand_b_select,
  output wb_sel_t    reg_writeback_select,
  output pc_sel_t    next_pc_select,
  output alu_fn_t    alu_function,
  output logic       data_mem_write_enable
);

  logic alt_op;
  logic branch_taken;

  // funct7 bit 5 selects SUB only for register ops, SRA/SRAI for both
  assign alt_op = inst_funct7[5];
  // Flag set means equal or "not less", funct3 picks the polarity
  assign branch_taken = alu_result_equal_zero ^ inst_funct3[0] ^ inst_funct3[2];

  always_comb begin
    regfile_write_enable  = 1'b0;
    alu_operand_a_select  = 1'b0;
    alu_operand_b_select  = 1'b0;
    reg_writeback_select  = wb_alu;
    next_pc_select        = pc_plus4;
    alu_function          = alu_add;
    data_mem_write_enable = 1'b0;
    case (inst_opcode)
      op_lui: begin
        regfile_write_enable = 1'b1;
        alu_operand_b_select = 1'b1;
        alu_function         = alu_pass_b;
        reg_writeback_select = wb_imm;
      end
      op_auipc: begin
        regfile_write_enable = 1'b1;
        alu_operand_a_select = 1'b1;
        alu_operand_b_select = 1'b1;
      end
      op_jal, op_jalr: begin
        regfile_write_enable = 1'b1;
        alu_operand_b_select = 1'b1;
        reg_writeback_select = wb_pc_plus4;
        next_pc_select       = (inst_opcode == op_jal) ? pc_plus_imm : pc_alu;
      end
      op_branch: begin
        case (inst_funct3[2:1])
          2'b10:   alu_function = alu_slt;
          2'b11:   alu_function = alu_sltu;
          default: alu_function = alu_sub;
        endcase
        next_pc_select = branch_taken ? pc_plus_imm : pc_plus4;
      end
      op_load: begin
        regfile_write_enable = 1'b1;
        alu_operand_b_select = 1'b1;
        reg_writeback_select = wb_mem;
      end
      op_store: begin
        alu_operand_b_select  = 1'b1;
        data_mem_write_enable = 1'b1;
      end
      op_imm, op_reg: begin
        regfile_write_enable = 1'b1;
        alu_operand_b_select = (inst_opcode == op_imm);
        case (inst_funct3)
          3'b000:  alu_function = (inst_opcode == op_reg && alt_op) ? alu_sub : alu_add;
          3'b001:  alu_function = alu_sll;
          3'b010:  alu_function = alu_slt;
          3'b011:  alu_function = alu_sltu;
          3'b100:  alu_function = alu_xor;
          3'b101:  alu_function = alt_op ? alu_sra : alu_srl;
          3'b110:  alu_function = alu_or;
          default: alu_function = alu_and;
        endcase
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: src/singlecycle_core.sv
// --------------------------------------
// RV32I single-cycle core, top level
// Both memories must answer within the cycle
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module singlecycle_core import rv_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic            clock,
  input  logic            arst_n,
  input  logic [xlen-1:0] inst,
  input  logic [xlen-1:0] data_mem_read_data,
  output logic [xlen-1:0] pc,
  output logic [xlen-1:0] data_mem_address,
  output logic [xlen-1:0] data_mem_write_data,
  output logic            data_mem_write_enable
);

  logic [6:0] inst_opcode, inst_funct7;
  logic [2:0] inst_funct3;
  logic       alu_result_equal_zero, regfile_write_enable;
  logic       alu_operand_a_select, alu_operand_b_select;
  wb_sel_t    reg_writeback_select;
  pc_sel_t    next_pc_select;
  alu_fn_t    alu_function;

  singlecycle_datapath #(.reset_pc(reset_pc)) datapath (.*);

  control_unit control (.*);

endmodule

`default_nettype wire

// File: verif/core_properties.sv
// --------------------------------------
// Assertions bound into the core top level
// Sampled on the rising clock edge
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module core_properties import rv_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input logic            clock,
  input logic            arst_n,
  input logic [xlen-1:0] pc,
  input logic [xlen-1:0] inst,
  input logic            data_mem_write_enable
);

  // No store may escape while the core is held in reset
  assert property (@(posedge clock) !arst_n |-> !data_mem_write_enable)
    else $error("data memory write enabled during reset");

  assert property (@(posedge clock) disable iff (!arst_n) pc[1:0] == 2'b00)
    else $error("pc is not word aligned");

  // First commit happens on the edge after release
  assert property (@(posedge clock)
    $rose(arst_n) |=> (pc == reset_pc || pc == reset_pc + 32'd4))
    else $error("pc after reset release is not reset_pc or reset_pc plus 4");

  assert property (@(posedge clock) data_mem_write_enable |-> inst[6:0] == op_store)
    else $error("data memory write enabled for an opcode other than store");

endmodule

bind singlecycle_core core_properties #(.reset_pc(reset_pc)) core_checks (
  .clock(clock),
  .arst_n(arst_n),
  .pc(pc),
  .inst(inst),
  .data_mem_write_enable(data_mem_write_enable)
);

`default_nettype wire

// File: verif/core_tb.sv
// --------------------------------------
// Each test runs a short program from reset
// Result is taken from the SW to 0x100
// Memories are 256 words indexed by address bits 9:2
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module core_tb import rv_pkg::*; ();

  localparam logic [xlen-1:0] start_pc = 32'h0000_0080;
  localparam logic [xlen-1:0] result_address = 32'h0000_0100;
  localparam int max_rows = 128;
  localparam int max_cycles = 40;

  typedef enum logic [3:0] {
    k_reg, k_imm, k_branch, k_lui, k_auipc, k_jal, k_jalr, k_mem, k_x0
  } kind_t;

  logic            clock, arst_n;
  logic [xlen-1:0] inst, data_mem_read_data, pc;
  logic [xlen-1:0] data_mem_address, data_mem_write_data;
  logic            data_mem_write_enable;
  logic [xlen-1:0] imem [256];
  logic [xlen-1:0] dmem [256];
  logic [15:0]     lfsr_state;
  int              rows, errors, failed_tests;

  // --------------------------------------
  // Test table
  // --------------------------------------
  string           row_name [max_rows];
  kind_t           row_kind [max_rows];
  logic [3:0]      row_code [max_rows];
  logic [xlen-1:0] row_a [max_rows], row_b [max_rows], row_expected [max_rows];

  // Mnemonics indexed by {funct7[5], funct3}
  string alu_name [16] = '{"add", "sll", "slt", "sltu", "xor", "srl", "or", "and",
                           "sub", "", "", "", "", "sra", "", ""};
  string branch_name [8] = '{"beq", "bne", "", "", "blt", "bge", "bltu", "bgeu"};
  logic [xlen-1:0] edge_a [3] = '{32'hffff_ffff, 32'h8000_0000, 32'h0000_0000};
  logic [xlen-1:0] edge_b [3] = '{32'h8000_0000, 32'hffff_ffff, 32'hffff_ffff};

  singlecycle_core #(.reset_pc(start_pc)) uut (.*);

  always #5 clock = ~clock;

  // Both memories answer in the same cycle
  // Instruction word held at zero in reset
  assign inst = arst_n ? imem[pc[9:2]] : '0;
  assign data_mem_read_data = dmem[data_mem_address[9:2]];

  always @(posedge clock) begin
    if (data_mem_write_enable)
      dmem[data_mem_address[9:2]] <= data_mem_write_data;
  end

  // Fibonacci LFSR with taps 16 14 13 11
  // One step per bit taken
  function automatic logic [xlen-1:0] random_bits(input int count);
    logic [xlen-1:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
      lfsr_state = {lfsr_state[14:0], value[0]};
    end
    return value;
  endfunction

  // Value of x3 at the result store by the RV32I rules
  function automatic logic [xlen-1:0] rule_result(input kind_t kind, input logic [3:0] code,
                                                  input logic [xlen-1:0] a, b);
    logic [xlen-1:0] operand, sra_value;
    logic less;
    operand = (kind == k_imm) ? {{20{b[11]}}, b[11:0]} : b;
    sra_value = $signed(a) >>> operand[4:0];
    less = code[1] ? (a < b) : ($signed(a) < $signed(b));
    case (kind)
      k_reg, k_imm: begin
        case (code)
          4'd0:    return a + operand;
          4'd8:    return a - operand;
          4'd1:    return a << operand[4:0];
          4'd2:    return {31'b0, $signed(a) < $signed(operand)};
          4'd3:    return {31'b0, a < operand};
          4'd4:    return a ^ operand;
          4'd5:    return a >> operand[4:0];
          4'd13:   return sra_value;
          4'd6:    return a | operand;
          default: return a & operand;
        endcase
      end
      // Taken branch skips the increment
      k_branch: return ((code[2] ? less : (a == b)) ^ code[0]) ? 32'd0 : 32'd1;
      k_lui:    return {b[31:12], 12'b0};
      k_auipc:  return {b[31:12], 12'b0} + start_pc + 32'd20;
      k_jal, k_jalr: return start_pc + 32'd24;
      k_mem:    return b;
      // x0 test reads x0 back
      default:  return '0;
    endcase
  endfunction

  task automatic add_row(input string name, input kind_t kind, input logic [3:0] code,
                         input logic [xlen-1:0] a, b);
    row_name[rows] = name;
    row_kind[rows] = kind;
    row_code[rows] = code;
    row_a[rows] = a;
    row_b[rows] = b;
    row_expected[rows] = rule_result(kind, code, a, b);
    rows++;
  endtask

  task automatic add_alu_rows(input kind_t kind, input logic [3:0] code, input string name);
    logic [xlen-1:0] a, b;
    a = random_bits(32);
    b = random_bits(32);
    add_row({name, "_random"}, kind, code, a, b);
    for (int e = 0; e < 3; e++) begin
      add_row($sformatf("%s_edge%0d", name, e), kind, code, edge_a[e], edge_b[e]);
    end
  endtask

  task automatic put_word(input int slot, input logic [xlen-1:0] word);
    imem[start_pc[9:2] + slot[7:0]] = word;
  endtask

  // --------------------------------------
  // Program loads x1 and x2 with LUI and ADDI
  // then clears x3 and runs the operation
  // Slot 6 precedes the SW of x3 to 0x100 and the spin
  // --------------------------------------
  task automatic load_program(input int r);
    logic [2:0] f3;
    logic alt;
    logic [xlen-1:0] a, b, op_word, next_word;
    f3 = row_code[r][2:0];
    alt = row_code[r][3];
    a = row_a[r];
    b = row_b[r];
    // Jumps and taken branches skip slot 6 which counts x3 up
    next_word = (row_kind[r] inside {k_branch, k_jal, k_jalr}) ?
                {12'd1, 5'd3, 3'd0, 5'd3, op_imm} : {12'd0, 5'd0, 3'd0, 5'd0, op_imm};
    case (row_kind[r])
      k_reg:    op_word = {1'b0, alt, 5'd0, 5'd2, 5'd1, f3, 5'd3, op_reg};
      k_imm:    op_word = {(f3[1:0] == 2'b01) ? {1'b0, alt, 5'd0, b[4:0]} : b[11:0],
                           5'd1, f3, 5'd3, op_imm};
      k_branch: op_word = {7'd0, 5'd2, 5'd1, f3, 5'b01000, op_branch};
      k_lui:    op_word = {b[31:12], 5'd3, op_lui};
      k_auipc:  op_word = {b[31:12], 5'd3, op_auipc};
      k_jal:    op_word = {1'b0, 10'd4, 1'b0, 8'd0, 5'd3, op_jal};
      k_jalr:   op_word = {b[11:0], 5'd1, 3'd0, 5'd3, op_jalr};
      k_mem: begin
        op_word = {7'd0, 5'd2, 5'd1, 3'b010, 5'd0, op_store};
        next_word = {12'd0, 5'd1, 3'b010, 5'd3, op_load};
      end
      default: begin
        op_word = {7'd0, 5'd2, 5'd1, 3'd0, 5'd0, op_reg};
        next_word = {7'd0, 5'd0, 5'd0, 3'd0, 5'd3, op_reg};
      end
    endcase
    // Upper part rounded up when ADDI adds a negative low part
    put_word(0, {a[31:12] + {19'd0, a[11]}, 5'd1, op_lui});
    put_word(1, {a[11:0], 5'd1, 3'd0, 5'd1, op_imm});
    put_word(2, {b[31:12] + {19'd0, b[11]}, 5'd2, op_lui});
    put_word(3, {b[11:0], 5'd2, 3'd0, 5'd2, op_imm});
    put_word(4, {12'd0, 5'd0, 3'd0, 5'd3, op_imm});
    put_word(5, op_word);
    put_word(6, next_word);
    put_word(7, {7'b0001000, 5'd3, 5'd0, 3'b010, 5'd0, op_store});
    put_word(8, {20'd0, 5'd0, op_jal});
  endtask

  task automatic check_value(input string name, input logic [xlen-1:0] expected, actual);
    if (actual !== expected) begin
      $display("error: %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic run_row(input int r);
    int cycles;
    int errors_before;
    logic stored;
    logic [xlen-1:0] stored_data, stored_pc;
    errors_before = errors;
    stored = 1'b0;
    cycles = 0;
    @(posedge clock);
    #1 arst_n = 1'b0;
    load_program(r);
    repeat (2) @(posedge clock);
    #1;
    check_value({row_name[r], " reset write enable"}, 32'd0, {31'd0, data_mem_write_enable});
    arst_n = 1'b1;
    #1;
    check_value({row_name[r], " first fetch"}, start_pc, pc);
    while (!stored && cycles < max_cycles) begin
      @(negedge clock);
      if (data_mem_write_enable && data_mem_address == result_address) begin
        stored = 1'b1;
        stored_data = data_mem_write_data;
        stored_pc = pc;
      end
      cycles++;
    end
    if (!stored) begin
      $display("%s: the result store did not happen within %0d cycles", row_name[r], max_cycles);
      errors++;
    end else begin
      check_value(row_name[r], row_expected[r], stored_data);
      check_value({row_name[r], " store pc"}, start_pc + 32'd28, stored_pc);
    end
    if (errors == errors_before) begin
      $display("%s: ok", row_name[r]);
    end else begin
      $display("%s: failed", row_name[r]);
      failed_tests++;
    end
  endtask

  initial begin
    logic [xlen-1:0] r;
    clock = 1'b0;
    arst_n = 1'b0;
    lfsr_state = 16'd57;
    rows = 0;
    errors = 0;
    failed_tests = 0;
    for (int code = 0; code < 16; code++) begin
      if (alu_name[code] != "") begin
        add_alu_rows(k_reg, 4'(code), alu_name[code]);
        if (code != 8)
          add_alu_rows(k_imm, 4'(code), {alu_name[code], "i"});
      end
    end
    for (int f = 0; f < 8; f++) begin
      if (branch_name[f] != "") begin
        r = random_bits(31);
        add_row({branch_name[f], "_equal"}, k_branch, 4'(f), r, r);
        add_row({branch_name[f], "_less"}, k_branch, 4'(f), r, r + 32'd1);
        add_row({branch_name[f], "_greater"}, k_branch, 4'(f), r + 32'd1, r);
        add_row({branch_name[f], "_sign"}, k_branch, 4'(f), 32'h8000_0000, 32'd1);
      end
    end
    add_row("lui", k_lui, 4'd0, 32'd0, random_bits(32));
    add_row("auipc", k_auipc, 4'd0, 32'd0, random_bits(32));
    add_row("jal", k_jal, 4'd0, 32'd0, 32'd0);
    // Odd target needs bit 0 dropped
    add_row("jalr_odd", k_jalr, 4'd0, start_pc + 32'd29, 32'd0);
    add_row("jalr_offset", k_jalr, 4'd0, start_pc + 32'd20, 32'd8);
    r = random_bits(6);
    add_row("lw_sw_random", k_mem, 4'd0, 32'h200 + (r << 2), random_bits(32));
    add_row("lw_sw_edge", k_mem, 4'd0, 32'h0000_02fc, 32'h8000_0000);
    // Nonzero sum shows any write that reaches x0
    add_row("x0_write", k_x0, 4'd0, 32'h1234_5678, 32'h0000_0001);
    for (int i = 0; i < rows; i++) begin
      run_row(i);
    end
    $display("%0d tests, %0d passed, %0d failed", rows, rows - failed_tests, failed_tests);
    if (failed_tests == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
src/rv_pkg.sv
src/alu.sv
src/regfile.sv
src/immediate_generator.sv
src/singlecycle_datapath.sv
src/control_unit.sv
src/singlecycle_core.sv
verif/core_properties.sv
verif/core_tb.sv

// File: Makefile
# Verilator flow for the single-cycle RV32I core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module core_tb -f project.f

run: build
	./obj_dir/Vcore_tb | tee sim.log
	grep -q "Verification passed" sim.log

lint:
	verilator --lint-only --timing --assert --top-module core_tb -f project.f

clean:
	rm -rf obj_dir sim.log
